//--- Makefile
# Verilator build and run of the execute core testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f list.f --top-module exec_core_tb -Mdir obj_dir

run: compile
	./obj_dir/Vexec_core_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/exec_core_tb.sv
// simulation top that runs directed tests on exec_core_top against a reference register model
module exec_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int NUM_INST    = 260;                    // upper bound on issued instructions
    localparam int CYCLE_LIMIT = NUM_INST * (64 + 4) + 100;

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
        logic [31:0]     due;    // sample cycle or zero for a multiply
    } exp_wb_t;

    logic            clk;
    logic            rst_n_i;
    logic [31:0]     inst_i;
    logic            inst_valid_i;
    logic            stall_o;
    wb_req_t         wb_o;
    logic            illegal_o;

    logic [XLEN-1:0] regs [0:31];  // reference register file
    exp_wb_t         exp_q [$];
    exp_wb_t         seen;
    int              cycles = 0;
    int              error_count;
    int              illegal_expected;
    int              illegal_seen;

    exec_core_top #(.MUL_BITS_PER_CYCLE(4)) dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .stall_o      (stall_o),
        .wb_o         (wb_o),
        .illegal_o    (illegal_o)
    );

    always #10 clk = ~clk;

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            report_failure($sformatf("run stopped by timeout after %0d cycles", cycles));
    end

    // compares each retire pulse in order against the expected queue
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (illegal_o)
                illegal_seen++;
            if (wb_o.valid) begin
                assert (exp_q.size() != 0) begin
                    seen = exp_q.pop_front();
                    assert (wb_o.rd == seen.rd) else
                        report_failure($sformatf("Fail at %0t: wb_o.rd got %0d expected %0d",
                                                 $time, wb_o.rd, seen.rd));
                    assert (wb_o.data == seen.data) else
                        report_failure($sformatf("Fail at %0t: wb_o.data got %h expected %h",
                                                 $time, wb_o.data, seen.data));
                    if (seen.due != 0)
                        assert (cycles == int'(seen.due)) else
                            report_failure($sformatf(
                                "Fail at %0t: wb_o.valid cycle got %0d expected %0d",
                                $time, cycles, seen.due));
                end else begin
                    report_failure("writeback seen with no instruction pending");
                end
            end
        end
    end

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [6:0] opc);
        rv_inst_u u;
        u.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: opc};
        return u;
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] opc);
        rv_inst_u u;
        u.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: opc};
        return u;
    endfunction

    // integer op result as the ISA defines it
    function automatic logic [XLEN-1:0] model_alu(input logic [2:0] f3, input logic alt,
                                                  input logic word, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic [XLEN-1:0]        r;
        logic [5:0]             sh;
        logic signed [31:0]     s32;
        logic signed [XLEN-1:0] s64;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << sh;
            3'd2: r = {63'd0, $signed(a) < $signed(b)};
            3'd3: r = {63'd0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (word && alt) begin
                    s32 = a[31:0];
                    s32 = s32 >>> sh;
                    r   = {32'd0, s32};
                end else if (word) begin
                    r = {32'd0, a[31:0] >> sh};
                end else if (alt) begin
                    s64 = a;
                    s64 = s64 >>> sh;
                    r   = s64;
                end else begin
                    r = a >> sh;
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        if (word)
            r = {{32{r[31]}}, r[31:0]};
        return r;
    endfunction

    // waits out the stall, drives one word and records what it must retire
    task automatic issue(input logic [31:0] word, input logic retires, input logic [4:0] rd,
                         input logic [XLEN-1:0] data, input logic fixed_latency);
        @(negedge clk);
        while (stall_o)
            @(negedge clk);
        inst_i       = word;
        inst_valid_i = 1'b1;
        if (retires) begin
            exp_q.push_back('{rd: rd, data: data, due: fixed_latency ? 32'(cycles + 2) : 32'd0});
            if (rd != 5'd0)
                regs[rd] = data;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            inst_valid_i = 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_q.size() != 0)
            @(negedge clk);
        idle(2);
    endtask

    task automatic reg_op(input logic [6:0] f7, input logic [2:0] f3, input logic word,
                          input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [XLEN-1:0] res;
        res = model_alu(f3, f7 == FUNCT7_ALT, word, regs[rs1], regs[rs2]);
        issue(r_type_word(f7, rs2, rs1, f3, rd, word ? OPC_OP_32 : OPC_OP), 1'b1, rd, res, 1'b1);
    endtask

    task automatic imm_op(input logic [11:0] imm, input logic [2:0] f3, input logic word,
                          input logic [4:0] rd, input logic [4:0] rs1);
        logic [XLEN-1:0] res;
        res = model_alu(f3, f3 == 3'd5 && imm[10], word, regs[rs1], {{52{imm[11]}}, imm});
        issue(i_type_word(imm, rs1, f3, rd, word ? OPC_OP_IMM_32 : OPC_OP_IMM),
              1'b1, rd, res, 1'b1);
    endtask

    task automatic lui_op(input logic [4:0] rd, input logic [19:0] upper);
        issue({upper, rd, OPC_LUI}, 1'b1, rd, {{32{upper[19]}}, upper, 12'd0}, 1'b1);
    endtask

    task automatic mul_op(input logic word, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2);
        logic [XLEN-1:0] prod;
        prod = regs[rs1] * regs[rs2];
        if (word)
            prod = {{32{prod[31]}}, prod[31:0]};
        issue(r_type_word(FUNCT7_MULDIV, rs2, rs1, 3'd0, rd, word ? OPC_OP_32 : OPC_OP),
              1'b1, rd, prod, 1'b0);
        @(negedge clk);
        assert (stall_o) else
            report_failure("stall_o stayed low after a multiply was accepted");
    endtask

    function automatic logic [4:0] any_reg();
        return 5'($urandom_range(31, 1));
    endfunction

    task automatic reset_state_test();
        assert (!stall_o && !wb_o.valid && !illegal_o) else
            report_failure("stall_o, wb_o.valid or illegal_o high after reset");
        for (int r = 1; r < 32; r++)
            reg_op(FUNCT7_BASE, 3'd0, 1'b0, 5'(r), 5'(r), 5'd0);
        drain();
    endtask

    task automatic base_ops_test();
        logic [2:0] f3;
        for (int r = 1; r < 32; r++) begin
            lui_op(5'(r), 20'($urandom));
            imm_op(12'($urandom), 3'd0, 1'b0, 5'(r), 5'(r));
        end
        for (int n = 0; n < 4; n++) begin
            for (int k = 0; k < 8; k++) begin
                f3 = 3'(k);
                reg_op(FUNCT7_BASE, f3, 1'b0, any_reg(), any_reg(), any_reg());
                if (f3 == 3'd0 || f3 == 3'd5)
                    reg_op(FUNCT7_ALT, f3, 1'b0, any_reg(), any_reg(), any_reg());
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm_op({6'd0, 6'($urandom)}, f3, 1'b0, any_reg(), any_reg());
                else
                    imm_op(12'($urandom), f3, 1'b0, any_reg(), any_reg());
            end
            imm_op({6'b010000, 6'($urandom)}, 3'd5, 1'b0, any_reg(), any_reg()); // srai
        end
        drain();
    endtask

    task automatic word_ops_test();
        lui_op(5'd5, 20'h80000 | 20'($urandom_range(255, 0)));
        imm_op(12'h7f3, 3'd0, 1'b0, 5'd5, 5'd5);
        lui_op(5'd6, 20'h7ffff);
        imm_op(12'd53, 3'd0, 1'b0, 5'd7, 5'd0);              // bit 5 ignored by word shifts
        reg_op(FUNCT7_BASE, 3'd0, 1'b1, 5'd8, 5'd5, 5'd6);   // addw
        reg_op(FUNCT7_ALT, 3'd0, 1'b1, 5'd9, 5'd5, 5'd6);    // subw
        reg_op(FUNCT7_BASE, 3'd1, 1'b1, 5'd10, 5'd5, 5'd7);  // sllw
        reg_op(FUNCT7_BASE, 3'd5, 1'b1, 5'd11, 5'd5, 5'd7);  // srlw
        reg_op(FUNCT7_ALT, 3'd5, 1'b1, 5'd12, 5'd5, 5'd7);   // sraw
        imm_op(12'h123, 3'd0, 1'b1, 5'd13, 5'd6);            // addiw
        imm_op(12'd4, 3'd1, 1'b1, 5'd14, 5'd6);
        imm_op({7'd0, 5'd3}, 3'd5, 1'b1, 5'd15, 5'd5);
        imm_op({7'b0100000, 5'd9}, 3'd5, 1'b1, 5'd16, 5'd5);
        drain();
    endtask

    task automatic chain_test();
        logic [4:0] prev;
        logic [4:0] next;
        prev = any_reg();
        for (int n = 0; n < 16; n++) begin
            next = any_reg();
            reg_op((n % 3 == 1) ? FUNCT7_ALT : FUNCT7_BASE, (n % 3 == 1) ? 3'd0 : 3'(n % 8),
                   1'b0, next, prev, any_reg());
            if (n % 4 == 3)
                idle(1);                                     // register-file path
            prev = next;
        end
        drain();
    endtask

    task automatic multiply_test();
        logic [4:0] rd;
        for (int n = 0; n < 6; n++) begin
            rd = any_reg();
            mul_op(n[0], rd, any_reg(), any_reg());
            reg_op(FUNCT7_BASE, 3'd0, 1'b0, any_reg(), rd, any_reg());
        end
        drain();
    endtask

    task automatic illegal_and_x0_test();
        issue(i_type_word(12'd0, 5'd1, 3'd3, 5'd2, 7'b0000011), 1'b0, 5'd0, '0, 1'b0);  // load
        illegal_expected++;
        issue(r_type_word(FUNCT7_MULDIV, 5'd3, 5'd1, 3'd4, 5'd2, OPC_OP), 1'b0, 5'd0, '0, 1'b0);
        illegal_expected++;
        imm_op(12'd5, 3'd0, 1'b0, 5'd0, 5'd0);               // addi writing x0
        reg_op(FUNCT7_BASE, 3'd0, 1'b0, 5'd1, 5'd0, 5'd0);
        drain();
        assert (illegal_seen == illegal_expected) else
            report_failure($sformatf("Fail at %0t: illegal_o pulses got %0d expected %0d",
                                     $time, illegal_seen, illegal_expected));
    endtask

    initial begin
        void'($urandom(32'hd8c5));
        clk              = 1'b0;
        rst_n_i          = 1'b0;
        inst_i           = '0;
        inst_valid_i     = 1'b0;
        error_count      = 0;
        illegal_expected = 0;
        illegal_seen     = 0;
        for (int r = 0; r < 32; r++)
            regs[r] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        reset_state_test();
        base_ops_test();
        word_ops_test();
        chain_test();
        multiply_test();
        illegal_and_x0_test();
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- list.f
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/id_stage.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/wb_stage.sv
logic/exec_core_top.sv
dv/exec_core_tb.sv

//--- logic/alu_unit.sv
// single-cycle integer ALU of the execute stage, also the forwarding source for decode
module alu_unit (
    input  pipe_pkg::ex_ctrl_t ex_ctrl_i,
    output pipe_pkg::wb_req_t  alu_res_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [5:0]      shamt;
    logic [XLEN-1:0] srl_in;
    logic [XLEN-1:0] sra_in;
    logic [XLEN-1:0] res;

    assign a = ex_ctrl_i.src_a;
    assign b = ex_ctrl_i.src_b;

    // word ops shift by 5 bits of the low word
    assign shamt  = ex_ctrl_i.word_op ? {1'b0, b[4:0]} : b[5:0];
    assign srl_in = ex_ctrl_i.word_op ? {{(XLEN-32){1'b0}}, a[31:0]} : a;
    assign sra_in = ex_ctrl_i.word_op ? {{(XLEN-32){a[31]}}, a[31:0]} : a;

    always_comb begin
        case (ex_ctrl_i.alu_op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_SLL:  res = a << shamt;
            ALU_SLT:  res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: res = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  res = a ^ b;
            ALU_SRL:  res = srl_in >> shamt;
            ALU_SRA:  res = $signed(sra_in) >>> shamt;
            ALU_OR:   res = a | b;
            ALU_AND:  res = a & b;
            default:  res = b;            // pass b for lui
        endcase
    end

    assign alu_res_o.valid = ex_ctrl_i.valid & ~ex_ctrl_i.is_mul;
    assign alu_res_o.rd    = ex_ctrl_i.rd;
    assign alu_res_o.data  = ex_ctrl_i.word_op ? {{(XLEN-32){res[31]}}, res[31:0]} : res;

endmodule

//--- logic/exec_core_top.sv
// top of the integer execute core: decode, ALU, multiplier and writeback wired together
module exec_core_top #(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [31:0]       inst_i,
    input  logic              inst_valid_i,
    output logic              stall_o,
    output pipe_pkg::wb_req_t wb_o,
    output logic              illegal_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    ex_ctrl_t        ex_ctrl;
    wb_req_t         alu_res;
    wb_req_t         mul_res;
    logic [4:0]      rf_raddr1;
    logic [4:0]      rf_raddr2;
    logic [XLEN-1:0] rf_rdata1;
    logic [XLEN-1:0] rf_rdata2;

    id_stage u_id_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .stall_i      (stall_o),
        .rf_raddr1_o  (rf_raddr1),
        .rf_raddr2_o  (rf_raddr2),
        .rf_rdata1_i  (rf_rdata1),
        .rf_rdata2_i  (rf_rdata2),
        .fwd_i        (alu_res),     // alu result bypass
        .ex_ctrl_o    (ex_ctrl),
        .illegal_o    (illegal_o)
    );

    alu_unit u_alu_unit (
        .ex_ctrl_i (ex_ctrl),
        .alu_res_o (alu_res)
    );

    mul_unit #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) u_mul_unit (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .ex_ctrl_i (ex_ctrl),
        .mul_res_o (mul_res),
        .stall_o   (stall_o)
    );

    wb_stage u_wb_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .alu_res_i   (alu_res),
        .mul_res_i   (mul_res),
        .rf_raddr1_i (rf_raddr1),
        .rf_raddr2_i (rf_raddr2),
        .rf_rdata1_o (rf_rdata1),
        .rf_rdata2_o (rf_rdata2),
        .wb_o        (wb_o)
    );

endmodule

//--- logic/id_stage.sv
// decode stage: turns each accepted instruction into the registered execute control word
module id_stage (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [31:0]                   inst_i,
    input  logic                          inst_valid_i,
    input  logic                          stall_i,
    output logic [4:0]                    rf_raddr1_o,
    output logic [4:0]                    rf_raddr2_o,
    input  logic [rv_isa_pkg::XLEN-1:0]   rf_rdata1_i,
    input  logic [rv_isa_pkg::XLEN-1:0]   rf_rdata2_i,
    input  pipe_pkg::wb_req_t             fwd_i,
    output pipe_pkg::ex_ctrl_t            ex_ctrl_o,
    output logic                          illegal_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    rv_inst_u          inst;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_u;
    logic [XLEN-1:0]   op1;
    logic [XLEN-1:0]   op2;
    logic              imm_alt;
    logic              illegal;
    logic              use_imm;
    logic              is_lui;
    logic              is_mul;
    logic              word_op;
    alu_op_e           alu_op;
    logic              accept;
    ex_ctrl_t          ctrl_d;
    ex_ctrl_t          ctrl_q;
    logic              illegal_q;

    function automatic alu_op_e base_op(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    // funct7 must be zero, or ALT on add/sub and right shifts
    function automatic logic alt_ok(input logic [6:0] funct7, input logic [2:0] funct3);
        return funct7 == FUNCT7_BASE ||
               (funct7 == FUNCT7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
    endfunction

    assign inst    = inst_i;
    assign imm_i   = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};
    assign imm_u   = {{(XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_alt = inst.r.funct7[5] & (inst.r.funct3 == F3_SR); // srai, sraiw
    assign accept  = inst_valid_i & ~stall_i;

    always_comb begin
        illegal = 1'b0;
        use_imm = 1'b1;
        is_lui  = 1'b0;
        is_mul  = 1'b0;
        word_op = 1'b0;
        alu_op  = ALU_ADD;
        case (inst.r.opcode)
            OPC_OP, OPC_OP_32: begin
                use_imm = 1'b0;
                word_op = inst.r.opcode == OPC_OP_32;
                if (inst.r.funct7 == FUNCT7_MULDIV) begin
                    is_mul  = 1'b1;
                    illegal = inst.r.funct3 != F3_MUL;     // div and high halves not here
                end else begin
                    alu_op  = base_op(inst.r.funct3, inst.r.funct7[5]);
                    illegal = !alt_ok(inst.r.funct7, inst.r.funct3);
                    if (word_op && !(inst.r.funct3 inside {F3_ADD, F3_SLL, F3_SR}))
                        illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                alu_op = base_op(inst.r.funct3, imm_alt);
                if (inst.r.funct3 == F3_SLL)
                    illegal = inst.r.funct7[6:1] != 6'd0;  // 6-bit shamt
                else if (inst.r.funct3 == F3_SR)
                    illegal = inst.r.funct7[6:1] != 6'd0 &&
                              inst.r.funct7[6:1] != FUNCT7_ALT[6:1];
            end
            OPC_OP_IMM_32: begin
                word_op = 1'b1;
                alu_op  = base_op(inst.r.funct3, imm_alt);
                if (inst.r.funct3 inside {F3_SLL, F3_SR})
                    illegal = !alt_ok(inst.r.funct7, inst.r.funct3);
                else
                    illegal = inst.r.funct3 != F3_ADD;     // only addiw
            end
            OPC_LUI: begin
                is_lui = 1'b1;
                alu_op = ALU_PASS_B;
            end
            default: illegal = 1'b1;
        endcase
    end

    assign rf_raddr1_o = inst.r.rs1;
    assign rf_raddr2_o = inst.r.rs2;

    // bypass the instruction now in execute
    assign op1 = (fwd_i.valid && fwd_i.rd == inst.r.rs1 && inst.r.rs1 != 5'd0) ?
                 fwd_i.data : rf_rdata1_i;
    assign op2 = (fwd_i.valid && fwd_i.rd == inst.r.rs2 && inst.r.rs2 != 5'd0) ?
                 fwd_i.data : rf_rdata2_i;

    always_comb begin
        ctrl_d.valid   = accept & ~illegal;  // bubble otherwise
        ctrl_d.is_mul  = is_mul;
        ctrl_d.word_op = word_op;
        ctrl_d.alu_op  = alu_op;
        ctrl_d.rd      = inst.r.rd;
        ctrl_d.src_a   = op1;
        ctrl_d.src_b   = is_lui ? imm_u : (use_imm ? imm_i : op2);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctrl_q.valid <= 1'b0;
            illegal_q    <= 1'b0;
        end else begin
            ctrl_q    <= ctrl_d;
            illegal_q <= accept & illegal;
        end
    end

    assign ex_ctrl_o = ctrl_q;
    assign illegal_o = illegal_q;

endmodule

//--- logic/mul_unit.sv
// iterative shift-add multiplier for mul and mulw, holds the front end while it works
module mul_unit #(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  pipe_pkg::ex_ctrl_t ex_ctrl_i,
    output pipe_pkg::wb_req_t  mul_res_o,
    output logic               stall_o
);
    import rv_isa_pkg::*;

    localparam int STEPS = XLEN / MUL_BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS);

    logic             start;
    logic             busy_q;
    logic             done_q;
    logic [CNT_W-1:0] cnt_q;   // steps left after this one
    logic [XLEN-1:0]  acc_q;
    logic [XLEN-1:0]  mcand_q;
    logic [XLEN-1:0]  mplier_q;
    logic [4:0]       rd_q;
    logic             word_q;
    logic [XLEN-1:0]  partial;

    assign start = ex_ctrl_i.valid & ex_ctrl_i.is_mul & ~busy_q;

    // sum of shifted multiplicands for the low multiplier bits
    always_comb begin
        partial = '0;
        for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
            if (mplier_q[i])
                partial = partial + (mcand_q << i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= busy_q && cnt_q == '0;   // one-cycle result pulse
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(STEPS - 1);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == '0)
                    busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc_q    <= '0;
            mcand_q  <= ex_ctrl_i.src_a;
            mplier_q <= ex_ctrl_i.src_b;
            rd_q     <= ex_ctrl_i.rd;
            word_q   <= ex_ctrl_i.word_op;
        end else if (busy_q) begin
            acc_q    <= acc_q + partial;
            mcand_q  <= mcand_q << MUL_BITS_PER_CYCLE;
            mplier_q <= mplier_q >> MUL_BITS_PER_CYCLE;
        end
    end

    assign mul_res_o.valid = done_q;
    assign mul_res_o.rd    = rd_q;
    assign mul_res_o.data  = word_q ? {{(XLEN-32){acc_q[31]}}, acc_q[31:0]} : acc_q;

    // issue cycle too, so nothing slips in behind the multiply
    assign stall_o = busy_q | done_q | (ex_ctrl_i.valid & ex_ctrl_i.is_mul);

endmodule

//--- logic/pipe_pkg.sv
// control words and result requests passed between the decode, execute and writeback stages
package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10 // lui
    } alu_op_e;

    // execute control word, registered by decode
    typedef struct packed {
        logic                          valid;
        logic                          is_mul;
        logic                          word_op;  // 32-bit op, result sign-extended
        alu_op_e                       alu_op;
        logic [4:0]                    rd;
        logic [rv_isa_pkg::XLEN-1:0]   src_a;
        logic [rv_isa_pkg::XLEN-1:0]   src_b;
    } ex_ctrl_t;

    // one result headed for the register file
    typedef struct packed {
        logic                          valid;
        logic [4:0]                    rd;
        logic [rv_isa_pkg::XLEN-1:0]   data;
    } wb_req_t;

endpackage

//--- logic/rv_isa_pkg.sv
// RV64 instruction encodings and the decoded instruction word, shared by decode and the testbench
package rv_isa_pkg;

    parameter int XLEN = 64; // integer register width

    // major opcodes handled by the execute core
    parameter logic [6:0] OPC_OP        = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM    = 7'b0010011;
    parameter logic [6:0] OPC_OP_32     = 7'b0111011;
    parameter logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    parameter logic [6:0] OPC_LUI       = 7'b0110111;

    parameter logic [6:0] FUNCT7_BASE   = 7'b0000000;
    parameter logic [6:0] FUNCT7_ALT    = 7'b0100000; // sub and arithmetic shift
    parameter logic [6:0] FUNCT7_MULDIV = 7'b0000001; // M extension

    parameter logic [2:0] F3_ADD  = 3'b000;
    parameter logic [2:0] F3_SLL  = 3'b001;
    parameter logic [2:0] F3_SLT  = 3'b010;
    parameter logic [2:0] F3_SLTU = 3'b011;
    parameter logic [2:0] F3_XOR  = 3'b100;
    parameter logic [2:0] F3_SR   = 3'b101; // srl or sra by funct7
    parameter logic [2:0] F3_OR   = 3'b110;
    parameter logic [2:0] F3_AND  = 3'b111;
    parameter logic [2:0] F3_MUL  = 3'b000; // low half product

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // same 32 bits, register form or immediate form
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } rv_inst_u;

endpackage

//--- logic/wb_stage.sv
// writeback stage: merges the unit results, owns the register file and drives the retire pulse
module wb_stage (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  pipe_pkg::wb_req_t             alu_res_i,
    input  pipe_pkg::wb_req_t             mul_res_i,
    input  logic [4:0]                    rf_raddr1_i,
    input  logic [4:0]                    rf_raddr2_i,
    output logic [rv_isa_pkg::XLEN-1:0]   rf_rdata1_o,
    output logic [rv_isa_pkg::XLEN-1:0]   rf_rdata2_o,
    output pipe_pkg::wb_req_t             wb_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0] rf_q [1:31];   // x0 not stored
    wb_req_t         merged;
    wb_req_t         wb_q;

    // units never finish in the same cycle
    assign merged = alu_res_i.valid ? alu_res_i : mul_res_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int r = 1; r < 32; r++)
                rf_q[r] <= '0;
        end else if (merged.valid && merged.rd != 5'd0) begin
            rf_q[merged.rd] <= merged.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i)
            wb_q.valid <= 1'b0;
        else
            wb_q <= merged;
    end

    // asynchronous read, x0 hardwired
    assign rf_rdata1_o = (rf_raddr1_i == 5'd0) ? '0 : rf_q[rf_raddr1_i];
    assign rf_rdata2_o = (rf_raddr2_i == 5'd0) ? '0 : rf_q[rf_raddr2_i];

    assign wb_o = wb_q;

endmodule
